// File: src/vend_settings.svh
`ifndef VEND_SETTINGS_SVH
`define VEND_SETTINGS_SVH

// coin values
`define VEND_COIN_SMALL 5
`define VEND_COIN_MID 10
`define VEND_COIN_LARGE 50

// drink prices, index 3 is the most expensive
`define VEND_PRICE_3 60
`define VEND_PRICE_2 30
`define VEND_PRICE_1 25
`define VEND_PRICE_0 20

// credit ceiling
`define VEND_CREDIT_MAX 99

// value of one returned coin
`define VEND_CHANGE_STEP 5

// consecutive high samples before a press counts
`define VEND_DEBOUNCE_DEPTH 8

// one returned coin per second at 100 MHz
`define VEND_RETURN_DIV 100000000

// digit scan rate of about 1 kHz
`define VEND_SCAN_DIV 100000

`endif

// File: src/vend_pkg.sv
`default_nettype none

package vend_pkg;

    // coin and cancel buttons
    typedef struct packed {
        logic coin_small;
        logic coin_mid;
        logic coin_large;
        logic cancel;
    } coin_btn_t;

    // one button per drink index
    typedef struct packed {
        logic drink_3;
        logic drink_2;
        logic drink_1;
        logic drink_0;
    } drink_btn_t;

    typedef logic [7:0] credit_t;

    // bit i set when drink i is affordable
    typedef logic [3:0] drink_mask_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] drink;
    } vend_t;

    // active-low digit enables and segments, dp last
    typedef struct packed {
        logic [3:0] an;
        logic [7:0] seg;
    } seg_out_t;

    typedef enum logic {
        ST_INSERT,
        ST_RETURN
    } vend_state_e;

endpackage

`default_nettype wire

// File: src/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

`include "vend_settings.svh"

module button_conditioner #(
    parameter type btn_t = logic [3:0]
) (
    input  wire       clk,
    input  wire       rst,
    input  wire btn_t raw,
    output btn_t      evt
);

    localparam int WIDTH = $bits(btn_t);
    localparam int DEPTH = `VEND_DEBOUNCE_DEPTH;

    logic [WIDTH-1:0] raw_bits;
    logic [WIDTH-1:0] pressed;
    logic [WIDTH-1:0] pressed_d;
    logic [WIDTH-1:0] evt_bits;

    assign raw_bits = raw;

    // one sample history per button
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        logic [DEPTH-1:0] history;

        always_ff @(posedge clk) begin
            if (rst) begin
                history <= '0;
            end else begin
                history <= {history[DEPTH-2:0], raw_bits[i]};
            end
        end

        // stable high over the whole window
        assign pressed[i] = &history;
    end

    // rising edge of the debounced level
    always_ff @(posedge clk) begin
        if (rst) begin
            pressed_d <= '0;
            evt_bits  <= '0;
        end else begin
            pressed_d <= pressed;
            evt_bits  <= pressed & ~pressed_d;
        end
    end

    assign evt = btn_t'(evt_bits);

endmodule

`default_nettype wire

// File: src/tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
    parameter int DIV = 100000
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    localparam int W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [W-1:0] LAST = W'(DIV - 1);

    logic [W-1:0] count;

    // wraps after DIV-1
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (count == LAST) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign tick = (count == LAST);

endmodule

`default_nettype wire

// File: src/vend_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "vend_settings.svh"

module vend_fsm
    import vend_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire coin_btn_t  coin_evt,
    input  wire drink_btn_t drink_evt,
    input  wire             return_tick,
    output credit_t         credit,
    output drink_mask_t     affordable,
    output vend_t           vend,
    output logic            dispense_coin
);

    localparam credit_t STEP = credit_t'(`VEND_CHANGE_STEP);

    vend_state_e state;
    vend_state_e state_next;
    credit_t     credit_next;
    vend_t       vend_next;
    logic        coin_next;
    logic [3:0]  drink_req;
    logic        buy_any;
    logic [1:0]  buy_idx;

    function automatic credit_t price_of(input logic [1:0] idx);
        case (idx)
            2'd3:    price_of = credit_t'(`VEND_PRICE_3);
            2'd2:    price_of = credit_t'(`VEND_PRICE_2);
            2'd1:    price_of = credit_t'(`VEND_PRICE_1);
            default: price_of = credit_t'(`VEND_PRICE_0);
        endcase
    endfunction

    // add with saturation at the credit ceiling
    function automatic credit_t add_coin(input credit_t base, input credit_t value);
        logic [8:0] sum;
        sum = {1'b0, base} + {1'b0, value};
        if (sum > 9'(`VEND_CREDIT_MAX)) begin
            add_coin = credit_t'(`VEND_CREDIT_MAX);
        end else begin
            add_coin = sum[7:0];
        end
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            affordable[i] = (credit >= price_of(2'(i)));
        end
    end

    assign drink_req = {drink_evt.drink_3, drink_evt.drink_2,
                        drink_evt.drink_1, drink_evt.drink_0};

    // highest affordable index wins
    always_comb begin
        buy_any = 1'b0;
        buy_idx = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (drink_req[i] && affordable[i]) begin
                buy_any = 1'b1;
                buy_idx = 2'(i);
            end
        end
    end

    always_comb begin
        state_next  = state;
        credit_next = credit;
        vend_next   = '0;
        coin_next   = 1'b0;
        case (state)
            ST_INSERT: begin
                if (coin_evt.coin_small) begin
                    credit_next = add_coin(credit, credit_t'(`VEND_COIN_SMALL));
                end else if (coin_evt.coin_mid) begin
                    credit_next = add_coin(credit, credit_t'(`VEND_COIN_MID));
                end else if (coin_evt.coin_large) begin
                    credit_next = add_coin(credit, credit_t'(`VEND_COIN_LARGE));
                end else if (buy_any) begin
                    credit_next     = credit - price_of(buy_idx);
                    vend_next.valid = 1'b1;
                    vend_next.drink = buy_idx;
                    state_next      = ST_RETURN;
                end else if (coin_evt.cancel && credit != '0) begin
                    state_next = ST_RETURN;
                end
            end
            ST_RETURN: begin
                // buttons are ignored while change is paid
                if (credit == '0) begin
                    state_next = ST_INSERT;
                end else if (return_tick) begin
                    coin_next = 1'b1;
                    if (credit <= STEP) begin
                        credit_next = '0;
                        state_next  = ST_INSERT;
                    end else begin
                        credit_next = credit - STEP;
                    end
                end
            end
            default: state_next = ST_INSERT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_INSERT;
            credit        <= '0;
            vend          <= '0;
            dispense_coin <= 1'b0;
        end else begin
            state         <= state_next;
            credit        <= credit_next;
            vend          <= vend_next;
            dispense_coin <= coin_next;
        end
    end

endmodule

`default_nettype wire

// File: src/credit_display.sv
`timescale 1ns/1ps
`default_nettype none

module credit_display
    import vend_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire credit_t credit,
    input  wire          scan_tick,
    output seg_out_t     display
);

    // 0 selects ones, 1 selects tens
    logic       sel;
    logic [3:0] tens;
    logic [7:0] ones;
    logic [7:0] digit;

    // common-anode pattern, segments a to g then dp
    function automatic logic [7:0] seg_pattern(input logic [7:0] value);
        case (value)
            8'd0:    seg_pattern = 8'b00000011;
            8'd1:    seg_pattern = 8'b10011111;
            8'd2:    seg_pattern = 8'b00100101;
            8'd3:    seg_pattern = 8'b00001101;
            8'd4:    seg_pattern = 8'b10011001;
            8'd5:    seg_pattern = 8'b01001001;
            8'd6:    seg_pattern = 8'b01000001;
            8'd7:    seg_pattern = 8'b00011111;
            8'd8:    seg_pattern = 8'b00000001;
            8'd9:    seg_pattern = 8'b00001001;
            // error pattern
            default: seg_pattern = 8'b01100000;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (scan_tick) begin
            sel <= ~sel;
        end
    end

    // tens by comparison, capped at 9
    always_comb begin
        tens = 4'd0;
        for (int t = 1; t <= 9; t++) begin
            if (credit >= credit_t'(t * 10)) begin
                tens = 4'(t);
            end
        end
    end

    // out of range credit leaves ones above 9
    assign ones = credit - 8'(tens * 10);

    assign digit = sel ? {4'b0000, tens} : ones;

    assign display.an  = sel ? 4'b1101 : 4'b1110;
    assign display.seg = seg_pattern(digit);

endmodule

`default_nettype wire

// File: src/vend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vend_settings.svh"

module vend_top
    import vend_pkg::*;
#(
    parameter int RETURN_DIV = `VEND_RETURN_DIV,
    parameter int SCAN_DIV   = `VEND_SCAN_DIV
) (
    input  wire             clk,
    input  wire             rst,
    input  wire coin_btn_t  coin_raw,
    input  wire drink_btn_t drink_raw,
    output drink_mask_t     affordable,
    output vend_t           vend,
    output logic            dispense_coin,
    output seg_out_t        display
);

    coin_btn_t  coin_evt;
    drink_btn_t drink_evt;
    logic       return_tick;
    logic       scan_tick;
    credit_t    credit;

    button_conditioner #(.btn_t(coin_btn_t)) u_coin_cond (
        .clk (clk),
        .rst (rst),
        .raw (coin_raw),
        .evt (coin_evt)
    );

    button_conditioner #(.btn_t(drink_btn_t)) u_drink_cond (
        .clk (clk),
        .rst (rst),
        .raw (drink_raw),
        .evt (drink_evt)
    );

    // pace of the change return
    tick_timer #(.DIV(RETURN_DIV)) u_return_timer (
        .clk  (clk),
        .rst  (rst),
        .tick (return_tick)
    );

    // digit multiplex rate
    tick_timer #(.DIV(SCAN_DIV)) u_scan_timer (
        .clk  (clk),
        .rst  (rst),
        .tick (scan_tick)
    );

    vend_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .coin_evt      (coin_evt),
        .drink_evt     (drink_evt),
        .return_tick   (return_tick),
        .credit        (credit),
        .affordable    (affordable),
        .vend          (vend),
        .dispense_coin (dispense_coin)
    );

    credit_display u_display (
        .clk       (clk),
        .rst       (rst),
        .credit    (credit),
        .scan_tick (scan_tick),
        .display   (display)
    );

endmodule

`default_nettype wire

// File: tests/vend_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "vend_settings.svh"

module vend_checker
    import vend_pkg::*;
(
    input wire              clk,
    input wire              rst,
    input wire vend_state_e state,
    input wire credit_t     credit,
    input wire vend_t       vend,
    input wire              dispense_coin
);

    int   failures = 0;
    logic off_grid;

    // saturation at 99 leaves the credit off the 5 grid until it empties
    always_ff @(posedge clk) begin
        if (rst) begin
            off_grid <= 1'b0;
        end else if (credit == '0) begin
            off_grid <= 1'b0;
        end else if (credit == credit_t'(`VEND_CREDIT_MAX)) begin
            off_grid <= 1'b1;
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit <= credit_t'(`VEND_CREDIT_MAX))
    else begin
        $error("credit above the ceiling");
        failures++;
    end

    a_credit_step: assert property (@(posedge clk) disable iff (rst)
        (credit % credit_t'(`VEND_CHANGE_STEP)) == '0
        || credit == credit_t'(`VEND_CREDIT_MAX) || off_grid)
    else begin
        $error("credit is not a multiple of the coin step");
        failures++;
    end

    a_vend_or_coin: assert property (@(posedge clk) disable iff (rst)
        !(vend.valid && dispense_coin))
    else begin
        $error("vend and returned coin in the same cycle");
        failures++;
    end

    // vend is registered, so the decision was taken one cycle earlier
    a_vend_source: assert property (@(posedge clk) disable iff (rst)
        vend.valid |-> $past(state) == ST_INSERT)
    else begin
        $error("vend issued outside the insert state");
        failures++;
    end

    a_no_rise: assert property (@(posedge clk) disable iff (rst)
        state == ST_RETURN |=> credit <= $past(credit))
    else begin
        $error("credit rose while returning change");
        failures++;
    end

endmodule

bind vend_fsm vend_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .credit        (credit),
    .vend          (vend),
    .dispense_coin (dispense_coin)
);

`default_nettype wire

// File: tests/vend_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vend_settings.svh"

module vend_top_tb
    import vend_pkg::*;
();

    localparam int HOLD          = `VEND_DEBOUNCE_DEPTH + 4;
    localparam int SETTLE_LIMIT  = 3000;
    localparam int STABLE_CYCLES = 12;

    // credit after the event and any refund, plus expected pulses
    typedef struct packed {
        logic [7:0] credit;
        logic       vend_valid;
        logic [1:0] vend_idx;
        logic [7:0] coins;
    } outcome_t;

    logic        clk = 1'b0;
    logic        rst;
    coin_btn_t   coin_raw;
    drink_btn_t  drink_raw;
    drink_mask_t affordable;
    vend_t       vend;
    logic        dispense_coin;
    seg_out_t    display;

    int vend_count    = 0;
    int coin_count    = 0;
    int last_vend_idx = 0;
    int shown_tens    = 15;
    int shown_ones    = 15;
    int error_count   = 0;
    int test_count    = 0;
    int failed_tests  = 0;
    int model_credit  = 0;

    vend_top #(.RETURN_DIV(20), .SCAN_DIV(4)) dut (
        .clk           (clk),
        .rst           (rst),
        .coin_raw      (coin_raw),
        .drink_raw     (drink_raw),
        .affordable    (affordable),
        .vend          (vend),
        .dispense_coin (dispense_coin),
        .display       (display)
    );

    always #5 clk = ~clk;

    function automatic int price(input int idx);
        case (idx)
            3:       return `VEND_PRICE_3;
            2:       return `VEND_PRICE_2;
            1:       return `VEND_PRICE_1;
            default: return `VEND_PRICE_0;
        endcase
    endfunction

    function automatic int mask_for(input int credit);
        int mask;
        mask = 0;
        for (int i = 0; i < 4; i++) begin
            if (credit >= price(i)) mask = mask | (1 << i);
        end
        return mask;
    endfunction

    // events 0 to 2 are coins, 3 is cancel, 4 to 7 are drinks 0 to 3
    function automatic outcome_t ref_step(input int credit, input int ev);
        outcome_t res;
        int       value;
        int       rest;
        res = '0;
        res.credit = 8'(credit);
        if (ev <= 2) begin
            value = (ev == 0) ? `VEND_COIN_SMALL : (ev == 1) ? `VEND_COIN_MID : `VEND_COIN_LARGE;
            value = credit + value;
            res.credit = 8'((value > `VEND_CREDIT_MAX) ? `VEND_CREDIT_MAX : value);
        end else if (ev == 3 && credit > 0) begin
            res.credit = 8'd0;
            res.coins = 8'((credit + `VEND_CHANGE_STEP - 1) / `VEND_CHANGE_STEP);
        end else if (ev >= 4 && credit >= price(ev - 4)) begin
            rest = credit - price(ev - 4);
            res.credit = 8'd0;
            res.vend_valid = 1'b1;
            res.vend_idx = 2'(ev - 4);
            res.coins = 8'((rest + `VEND_CHANGE_STEP - 1) / `VEND_CHANGE_STEP);
        end
        return res;
    endfunction

    // common-anode patterns back to digits, 15 for anything else
    function automatic int decode_seg(input logic [7:0] seg);
        case (seg)
            8'b00000011: return 0;
            8'b10011111: return 1;
            8'b00100101: return 2;
            8'b00001101: return 3;
            8'b10011001: return 4;
            8'b01001001: return 5;
            8'b01000001: return 6;
            8'b00011111: return 7;
            8'b00000001: return 8;
            8'b00001001: return 9;
            default:     return 15;
        endcase
    endfunction

    function automatic int shown_credit();
        if (shown_tens > 9 || shown_ones > 9) return -1;
        return shown_tens * 10 + shown_ones;
    endfunction

    // sampled before the DUT registers update
    always @(posedge clk) begin
        if (!rst) begin
            if (vend.valid) begin
                vend_count++;
                last_vend_idx = int'(vend.drink);
            end
            if (dispense_coin) coin_count++;
            if (display.an == 4'b1110) begin
                shown_ones = decode_seg(display.seg);
            end else if (display.an == 4'b1101) begin
                shown_tens = decode_seg(display.seg);
            end
        end
    end

    task automatic check_value(input string test_name, input string field,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic press(input int ev);
        @(negedge clk);
        case (ev)
            0:       coin_raw.coin_small = 1'b1;
            1:       coin_raw.coin_mid = 1'b1;
            2:       coin_raw.coin_large = 1'b1;
            3:       coin_raw.cancel = 1'b1;
            4:       drink_raw.drink_0 = 1'b1;
            5:       drink_raw.drink_1 = 1'b1;
            6:       drink_raw.drink_2 = 1'b1;
            default: drink_raw.drink_3 = 1'b1;
        endcase
        repeat (HOLD) @(negedge clk);
        coin_raw = '0;
        drink_raw = '0;
        repeat (HOLD) @(negedge clk);
    endtask

    // outputs must hold the expected values long enough for a full scan
    task automatic settle_and_check(input string test_name, input int exp_credit,
                                    input int exp_vends, input int exp_coins);
        int stable;
        int cycles;
        stable = 0;
        cycles = 0;
        while (stable < STABLE_CYCLES && cycles < SETTLE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (shown_credit() == exp_credit && int'(affordable) == mask_for(exp_credit)
                && vend_count == exp_vends && coin_count == exp_coins) begin
                stable++;
            end else begin
                stable = 0;
            end
        end
        if (stable < STABLE_CYCLES) begin
            $display("%s: outputs did not settle to the expected values in time", test_name);
            error_count++;
        end
        check_value(test_name, "credit", exp_credit, shown_credit());
        check_value(test_name, "affordable", mask_for(exp_credit), int'(affordable));
        check_value(test_name, "vend pulses", exp_vends, vend_count);
        check_value(test_name, "coin pulses", exp_coins, coin_count);
    endtask

    task automatic apply_event(input string test_name, input int ev);
        outcome_t want;
        int       vends;
        int       coins;
        want = ref_step(model_credit, ev);
        vends = vend_count + int'(want.vend_valid);
        coins = coin_count + int'(want.coins);
        press(ev);
        settle_and_check(test_name, int'(want.credit), vends, coins);
        if (want.vend_valid) begin
            check_value(test_name, "vend index", int'(want.vend_idx), last_vend_idx);
        end
        model_credit = int'(want.credit);
    endtask

    task automatic end_test(input string test_name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, error_count - errs_before);
        end
    endtask

    initial begin
        int       errs;
        outcome_t want;
        int       vends;
        int       coins;
        void'($urandom(16));
        rst = 1'b1;
        coin_raw = '0;
        drink_raw = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs = error_count;
        settle_and_check("reset", 0, 0, 0);
        end_test("reset", errs);

        errs = error_count;
        repeat (5) apply_event("coins", int'($urandom_range(2)));
        apply_event("coins", 2);
        apply_event("coins", 2);
        check_value("coins", "full mask", 15, int'(affordable));
        end_test("coins", errs);

        errs = error_count;
        apply_event("purchase", 7);
        end_test("purchase", errs);

        errs = error_count;
        apply_event("no_funds", 1);
        apply_event("no_funds", 4);
        end_test("no_funds", errs);

        errs = error_count;
        apply_event("cancel", 3);
        apply_event("cancel", 3);
        end_test("cancel", errs);

        // presses land while the 50 is still being paid back
        errs = error_count;
        apply_event("busy", 2);
        want = ref_step(model_credit, 3);
        vends = vend_count + int'(want.vend_valid);
        coins = coin_count + int'(want.coins);
        press(3);
        press(2);
        press(4);
        press(0);
        settle_and_check("busy", int'(want.credit), vends, coins);
        model_credit = int'(want.credit);
        end_test("busy", errs);

        $display("tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 test_count, failed_tests, error_count, dut.u_fsm.u_checker.failures);
        if (error_count == 0 && dut.u_fsm.u_checker.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vend.f
+incdir+src
src/vend_pkg.sv
src/button_conditioner.sv
src/tick_timer.sv
src/vend_fsm.sv
src/credit_display.sv
src/vend_top.sv
tests/vend_checker.sv
tests/vend_top_tb.sv

// File: Makefile
TOP := vend_top_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f vend.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
